// File: all.f
slurm16_pkg.sv
slurm16_cpu_registers.sv
slurm16_cpu_execute.sv
slurm16_cpu_alu.sv
slurm16_cpu_exec_unit.sv
tb_slurm16_checks.sv
tb_slurm16_exec_unit.sv

// File: run.sh
#!/bin/sh
# build and run the execute slice testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_slurm16_exec_unit -f all.f -o sim_exec_unit
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_exec_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
	echo "failure reported in $LOG"
	exit 1
fi
echo "simulation passed"
exit 0

// File: slurm16_cpu_alu.sv
module slurm16_cpu_alu #(
	parameter int BITS = 16
) (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  slurm16_pkg::alu_op_t  alu_op,
	input  logic [BITS-1:0]       alu_a,
	input  logic [BITS-1:0]       alu_b,
	input  slurm16_pkg::reg_idx_t alu_dest,
	input  logic                  alu_valid,
	input  logic                  int_flag_set,
	input  logic                  int_flag_clear,
	output logic                  wb_en,
	output slurm16_pkg::reg_idx_t wb_reg,
	output logic [BITS-1:0]       wb_data,
	output logic                  Z,
	output logic                  C,
	output logic                  S,
	output logic                  I
);

	import slurm16_pkg::*;

	logic [BITS:0]   ext; // carry out in top bit
	logic [BITS-1:0] res;
	logic            z_n;
	logic            c_n;
	logic            s_n;
	logic            upd_zs;

	// ============================================================
	// result and next flags
	// ============================================================

	always_comb begin
		ext    = '0;
		res    = alu_a;
		c_n    = C;
		upd_zs = 1'b1;
		case (alu_op)
			ALU_MOV: begin
				res    = alu_b;
				upd_zs = 1'b0; // flags untouched
			end
			ALU_ADD: ext = {1'b0, alu_a} + {1'b0, alu_b};
			ALU_ADC: ext = {1'b0, alu_a} + {1'b0, alu_b} + {{BITS{1'b0}}, C};
			ALU_SUB, ALU_CMP: ext = {1'b0, alu_a} - {1'b0, alu_b}; // carry is borrow
			ALU_SBB: ext = {1'b0, alu_a} - {1'b0, alu_b} - {{BITS{1'b0}}, C};
			ALU_AND, ALU_TEST: begin
				res = alu_a & alu_b;
				c_n = 1'b0;
			end
			ALU_OR: begin
				res = alu_a | alu_b;
				c_n = 1'b0;
			end
			ALU_XOR: begin
				res = alu_a ^ alu_b;
				c_n = 1'b0;
			end
			ALU_ASR: res = {alu_a[BITS-1], alu_a[BITS-1:1]};
			ALU_LSR: res = {1'b0, alu_a[BITS-1:1]};
			ALU_LSL: res = {alu_a[BITS-2:0], 1'b0};
			ALU_ROLC: begin
				res = {alu_a[BITS-2:0], C};
				c_n = alu_a[BITS-1];
			end
			ALU_RORC: begin
				res = {C, alu_a[BITS-1:1]};
				c_n = alu_a[0];
			end
			default: upd_zs = 1'b0;
		endcase
		if (alu_op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB, ALU_CMP}) begin
			res = ext[BITS-1:0];
			c_n = ext[BITS];
		end
		z_n = upd_zs ? (res == '0) : Z;
		s_n = upd_zs ? res[BITS-1] : S;
	end

	// ============================================================
	// status and writeback registers
	// ============================================================

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wb_en <= 1'b0;
			Z     <= 1'b0;
			C     <= 1'b0;
			S     <= 1'b0;
			I     <= 1'b0;
		end else begin
			wb_en <= alu_valid && writes_back(alu_op);
			if (alu_valid) begin
				Z <= z_n;
				C <= c_n;
				S <= s_n;
			end
			if (int_flag_set)
				I <= 1'b1;
			else if (int_flag_clear)
				I <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (alu_valid) begin
			wb_reg  <= alu_dest;
			wb_data <= res;
		end
	end

	a_int_flag_excl: assert property (@(posedge CLK) disable iff (!RSTb)
		!(int_flag_set && int_flag_clear));

endmodule

// File: slurm16_cpu_exec_unit.sv
module slurm16_cpu_exec_unit #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 16
) (
	input  logic                    CLK,
	input  logic                    RSTb,
	input  logic                    issue_valid,
	output logic                    issue_ready,
	input  logic [BITS-1:0]         instruction,
	input  logic [BITS-1:0]         imm,
	output logic                    load_memory,
	output logic                    store_memory,
	output logic [ADDRESS_BITS-1:0] load_store_address,
	output logic [BITS-1:0]         memory_out,
	output logic                    port_rd,
	output logic                    port_wr,
	output logic [ADDRESS_BITS-1:0] port_address,
	output logic [BITS-1:0]         port_out,
	output logic                    load_pc,
	output logic [ADDRESS_BITS-1:0] new_pc,
	output logic                    wb_en,
	output slurm16_pkg::reg_idx_t   wb_reg,
	output logic [BITS-1:0]         wb_data,
	output logic                    Z,
	output logic                    C,
	output logic                    S,
	output logic                    I
);

	import slurm16_pkg::*;

	logic [BITS-1:0] reg_a;
	logic [BITS-1:0] reg_b;
	alu_op_t         alu_op;
	logic [BITS-1:0] alu_a;
	logic [BITS-1:0] alu_b;
	reg_idx_t        alu_dest;
	logic            alu_valid;
	logic            int_flag_set;
	logic            int_flag_clear;

	slurm16_cpu_registers #(.BITS(BITS)) u_registers (
		.CLK(CLK), .RSTb(RSTb),
		.ra_idx(instruction[7:4]), .rb_idx(instruction[3:0]), // regA / regB fields
		.ra_data(reg_a), .rb_data(reg_b),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	slurm16_cpu_execute #(.BITS(BITS), .ADDRESS_BITS(ADDRESS_BITS)) u_execute (
		.CLK(CLK), .RSTb(RSTb),
		.instruction(instruction), .imm(imm),
		.issue_valid(issue_valid), .issue_ready(issue_ready),
		.regA(reg_a), .regB(reg_b), .Z(Z), .C(C), .S(S),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
		.alu_dest(alu_dest), .alu_valid(alu_valid),
		.load_memory(load_memory), .store_memory(store_memory),
		.load_store_address(load_store_address), .memory_out(memory_out),
		.port_rd(port_rd), .port_wr(port_wr),
		.port_address(port_address), .port_out(port_out),
		.load_pc(load_pc), .new_pc(new_pc),
		.int_flag_set(int_flag_set), .int_flag_clear(int_flag_clear)
	);

	slurm16_cpu_alu #(.BITS(BITS)) u_alu (
		.CLK(CLK), .RSTb(RSTb),
		.alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
		.alu_dest(alu_dest), .alu_valid(alu_valid),
		.int_flag_set(int_flag_set), .int_flag_clear(int_flag_clear),
		.wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.Z(Z), .C(C), .S(S), .I(I)
	);

endmodule

// File: slurm16_cpu_execute.sv
module slurm16_cpu_execute #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 16
) (
	input  logic                     CLK,
	input  logic                     RSTb,
	input  logic [BITS-1:0]          instruction,
	input  logic [BITS-1:0]          imm,
	input  logic                     issue_valid,
	output logic                     issue_ready,
	input  logic [BITS-1:0]          regA,
	input  logic [BITS-1:0]          regB,
	input  logic                     Z,
	input  logic                     C,
	input  logic                     S,
	output slurm16_pkg::alu_op_t     alu_op,
	output logic [BITS-1:0]          alu_a,
	output logic [BITS-1:0]          alu_b,
	output slurm16_pkg::reg_idx_t    alu_dest,
	output logic                     alu_valid,
	output logic                     load_memory,
	output logic                     store_memory,
	output logic [ADDRESS_BITS-1:0]  load_store_address,
	output logic [BITS-1:0]          memory_out,
	output logic                     port_rd,
	output logic                     port_wr,
	output logic [ADDRESS_BITS-1:0]  port_address,
	output logic [BITS-1:0]          port_out,
	output logic                     load_pc,
	output logic [ADDRESS_BITS-1:0]  new_pc,
	output logic                     int_flag_set,
	output logic                     int_flag_clear
);

	import slurm16_pkg::*;

	ins_class_t cls;
	reg_idx_t   ra_f;
	reg_idx_t   rb_f;
	logic       is_alu;
	logic       is_executing;
	logic       reads_a;
	logic       reads_b;
	logic       hazard;
	logic [1:0] pend_alu; // [0] execute stage, [1] alu stage
	logic [1:0] pend_wb;
	reg_idx_t   pend_dst [2];

	assign cls          = ins_class(instruction);
	assign ra_f         = instruction[7:4];
	assign rb_f         = instruction[3:0];
	assign is_alu       = cls inside {INS_ALU_SINGLE, INS_ALU_REG, INS_ALU_IMM};
	assign is_executing = issue_valid && issue_ready;
	assign alu_valid    = pend_alu[0];

	// ============================================================
	// hazard interlock
	// ============================================================

	always_comb begin
		reads_a = cls inside {INS_ALU_SINGLE, INS_ALU_REG, INS_ALU_IMM, INS_BRANCH, INS_RET,
			INS_LOAD_STORE, INS_PEEK_POKE};
		reads_b = cls inside {INS_ALU_REG, INS_LOAD_STORE, INS_PEEK_POKE};
		hazard  = 1'b0;
		for (int i = 0; i < 2; i++) begin
			if (pend_wb[i] && ((reads_a && pend_dst[i] == ra_f) || (reads_b && pend_dst[i] == rb_f)))
				hazard = 1'b1;
		end
		if (cls == INS_BRANCH && |pend_alu)
			hazard = 1'b1; // flags not settled yet
	end

	assign issue_ready = !hazard;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pend_alu <= '0;
			pend_wb  <= '0;
		end else begin
			pend_alu <= {pend_alu[0], is_executing && is_alu};
			pend_wb  <= {pend_wb[0], is_executing && is_alu && writes_back(alu_op_from_ins(instruction))};
		end
	end

	// ============================================================
	// alu operand registers
	// ============================================================

	always_ff @(posedge CLK) begin
		pend_dst[1] <= pend_dst[0];
		if (is_executing && is_alu) begin
			alu_op      <= alu_op_from_ins(instruction);
			alu_a       <= regA;
			alu_b       <= (cls == INS_ALU_IMM) ? imm : regB; // immediate form
			alu_dest    <= ra_f;
			pend_dst[0] <= ra_f;
		end
	end

	// ============================================================
	// branch, memory, port, interrupt flag
	// ============================================================

	always_comb begin
		load_pc            = 1'b0;
		new_pc             = '0;
		load_memory        = 1'b0;
		store_memory       = 1'b0;
		load_store_address = '0;
		memory_out         = '0;
		port_rd            = 1'b0;
		port_wr            = 1'b0;
		port_address       = '0;
		port_out           = '0;
		int_flag_set       = 1'b0;
		int_flag_clear     = 1'b0;
		if (is_executing) begin
			case (cls)
				INS_BRANCH: begin
					if (branch_taken(instruction, Z, C, S)) begin
						load_pc = 1'b1;
						new_pc  = ADDRESS_BITS'(regA + imm);
					end
				end
				INS_RET: begin
					load_pc = 1'b1;
					new_pc  = ADDRESS_BITS'(regA);
				end
				INS_INT: begin
					load_pc = 1'b1;
					new_pc  = ADDRESS_BITS'({instruction[3:0], 1'b0}); // vector times two
				end
				INS_LOAD_STORE: begin
					load_store_address = ADDRESS_BITS'(regB + imm);
					if (is_store(instruction)) begin
						store_memory = 1'b1;
						memory_out   = regA;
					end else begin
						load_memory = 1'b1;
					end
				end
				INS_PEEK_POKE: begin
					port_address = ADDRESS_BITS'(regB + imm);
					if (is_poke(instruction)) begin
						port_wr  = 1'b1;
						port_out = regA;
					end else begin
						port_rd = 1'b1;
					end
				end
				INS_INT_EN: begin
					int_flag_set   = is_int_enable(instruction);
					int_flag_clear = !is_int_enable(instruction);
				end
				default: ;
			endcase
		end
	end

endmodule

// File: slurm16_cpu_registers.sv
module slurm16_cpu_registers #(
	parameter int BITS = 16
) (
	input  logic                  CLK,
	input  logic                  RSTb,
	input  slurm16_pkg::reg_idx_t ra_idx,
	input  slurm16_pkg::reg_idx_t rb_idx,
	output logic [BITS-1:0]       ra_data,
	output logic [BITS-1:0]       rb_data,
	input  logic                  wb_en,
	input  slurm16_pkg::reg_idx_t wb_reg,
	input  logic [BITS-1:0]       wb_data
);

	import slurm16_pkg::*;

	localparam int NUM_REGS = 1 << $bits(reg_idx_t);

	logic [BITS-1:0] regs [NUM_REGS];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wb_en) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// write-through so a result is readable in its writeback cycle
	always_comb begin
		ra_data = regs[ra_idx];
		rb_data = regs[rb_idx];
		if (wb_en && wb_reg == ra_idx)
			ra_data = wb_data;
		if (wb_en && wb_reg == rb_idx)
			rb_data = wb_data;
	end

	a_wb_reg_known: assert property (@(posedge CLK) disable iff (!RSTb)
		wb_en |-> !$isunknown(wb_reg))
		else $error("wb_reg unknown during writeback");

endmodule

// File: slurm16_pkg.sv
package slurm16_pkg;

	// ============================================================
	// word types
	// ============================================================

	typedef logic [15:0] word_t;
	typedef logic [15:0] addr_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [3:0]  br_cond_t;

	// instruction class, bits 15..12
	typedef enum logic [3:0] {
		INS_NOP        = 4'd0,
		INS_ALU_SINGLE = 4'd1,
		INS_ALU_REG    = 4'd2,
		INS_ALU_IMM    = 4'd3,
		INS_BRANCH     = 4'd4,
		INS_RET        = 4'd5,
		INS_INT        = 4'd6,
		INS_LOAD_STORE = 4'd7,
		INS_PEEK_POKE  = 4'd8,
		INS_INT_EN     = 4'd9
	} ins_class_t;

	// two-operand ops below 16, single-register ops from 16 up
	typedef enum logic [4:0] {
		ALU_MOV  = 5'd0,
		ALU_ADD  = 5'd1,
		ALU_ADC  = 5'd2,
		ALU_SUB  = 5'd3,
		ALU_SBB  = 5'd4,
		ALU_AND  = 5'd5,
		ALU_OR   = 5'd6,
		ALU_XOR  = 5'd7,
		ALU_CMP  = 5'd8,
		ALU_TEST = 5'd9,
		ALU_ASR  = 5'd16,
		ALU_LSR  = 5'd17,
		ALU_LSL  = 5'd18,
		ALU_ROLC = 5'd19,
		ALU_RORC = 5'd20
	} alu_op_t;

	localparam br_cond_t BR_ALWAYS = 4'd0;
	localparam br_cond_t BR_Z      = 4'd1;
	localparam br_cond_t BR_NZ     = 4'd2;
	localparam br_cond_t BR_C      = 4'd3;
	localparam br_cond_t BR_NC     = 4'd4;
	localparam br_cond_t BR_S      = 4'd5;
	localparam br_cond_t BR_NS     = 4'd6;

	// ============================================================
	// decode helpers
	// ============================================================

	function automatic ins_class_t ins_class(input word_t ins);
		return ins_class_t'(ins[15:12]);
	endfunction

	function automatic alu_op_t alu_op_from_ins(input word_t ins);
		alu_op_t op;
		op = ALU_MOV; // unknown codes fall back to mov
		if (ins_class(ins) == INS_ALU_SINGLE) begin
			if (ins[11:8] <= 4'd4)
				op = alu_op_t'({1'b1, ins[11:8]});
		end else if (ins[11:8] <= 4'd9) begin
			op = alu_op_t'({1'b0, ins[11:8]});
		end
		return op;
	endfunction

	function automatic logic branch_taken(input word_t ins, input logic z, input logic c,
			input logic s);
		br_cond_t cond;
		cond = ins[11:8];
		case (cond)
			BR_ALWAYS: return 1'b1;
			BR_Z:      return z;
			BR_NZ:     return !z;
			BR_C:      return c;
			BR_NC:     return !c;
			BR_S:      return s;
			BR_NS:     return !s;
			default:   return 1'b0;
		endcase
	endfunction

	function automatic logic is_store(input word_t ins);
		return ins[8];
	endfunction

	function automatic logic is_poke(input word_t ins);
		return ins[8];
	endfunction

	function automatic logic is_int_enable(input word_t ins);
		return ins[0];
	endfunction

	function automatic logic writes_back(input alu_op_t op);
		return !(op == ALU_CMP || op == ALU_TEST); // compare and test touch flags only
	endfunction

endpackage

// File: tb_slurm16_checks.sv
module tb_slurm16_checks (
	input logic                  CLK,
	input logic                  RSTb,
	input logic                  issue_valid,
	input logic                  issue_ready,
	input slurm16_pkg::word_t    instruction,
	input slurm16_pkg::word_t    imm,
	input logic                  load_memory,
	input logic                  store_memory,
	input slurm16_pkg::addr_t    load_store_address,
	input slurm16_pkg::word_t    memory_out,
	input logic                  port_rd,
	input logic                  port_wr,
	input slurm16_pkg::addr_t    port_address,
	input slurm16_pkg::word_t    port_out,
	input logic                  load_pc,
	input slurm16_pkg::addr_t    new_pc,
	input logic                  wb_en,
	input slurm16_pkg::reg_idx_t wb_reg,
	input slurm16_pkg::word_t    wb_data,
	input logic                  Z,
	input logic                  C,
	input logic                  S,
	input logic                  I
);

	timeunit 1ns;
	timeprecision 100ps;

	import slurm16_pkg::*;

	word_t      shadow [16]; // reference register file
	logic       m_z;
	logic       m_c;
	logic       m_s;
	logic       m_i;
	logic [1:0] p_v; // [0] execute stage, [1] alu stage
	logic [1:0] p_wb;
	reg_idx_t   p_dst [2];
	word_t      p_data [2];
	logic [2:0] p_zcs [2];
	int         stalls;
	int         errors = 0;

	logic [3:0] cls;
	logic [3:0] op;
	word_t      a_val;
	word_t      b_reg;
	word_t      b_val;
	word_t      res;
	logic       c_new;
	logic       z_new;
	logic       s_new;
	logic       keep_zs;
	logic       does_wb;
	logic       is_alu;
	logic       acc;
	logic       reads_a;
	logic       reads_b;
	logic       hazard;
	logic       exp_ready;
	logic       exp_pc_ld;
	addr_t      exp_pc;
	addr_t      exp_addr;
	logic [1:0] exp_mem; // {load, store}
	logic [1:0] exp_port; // {rd, wr}

	task automatic report_mismatch(input string name, input logic [15:0] expv,
			input logic [15:0] actv);
		errors++;
		$display("ERROR %s expected %h actual %h at %0t", name, expv, actv, $time);
	endtask

	// ============================================================
	// reference alu
	// ============================================================

	always_comb begin
		cls     = instruction[15:12];
		op      = instruction[11:8];
		a_val   = shadow[instruction[7:4]];
		b_reg   = shadow[instruction[3:0]];
		b_val   = (cls == INS_ALU_IMM) ? imm : b_reg;
		res     = a_val;
		c_new   = m_c;
		keep_zs = 1'b0;
		if (cls == INS_ALU_SINGLE) begin
			case (op)
				4'd0: res = {a_val[15], a_val[15:1]}; // asr
				4'd1: res = {1'b0, a_val[15:1]};
				4'd2: res = {a_val[14:0], 1'b0};
				4'd3: {c_new, res} = {a_val, m_c}; // rolc
				default: {res, c_new} = {m_c, a_val}; // rorc
			endcase
		end else begin
			case (op)
				4'd0: begin
					res     = b_val;
					keep_zs = 1'b1; // mov keeps every flag
				end
				4'd1: {c_new, res} = {1'b0, a_val} + {1'b0, b_val};
				4'd2: {c_new, res} = {1'b0, a_val} + {1'b0, b_val} + 17'(m_c);
				4'd3, 4'd8: {c_new, res} = {1'b0, a_val} - {1'b0, b_val};
				4'd4: {c_new, res} = {1'b0, a_val} - {1'b0, b_val} - 17'(m_c);
				4'd5, 4'd9: {c_new, res} = {1'b0, a_val & b_val};
				4'd6: {c_new, res} = {1'b0, a_val | b_val};
				default: {c_new, res} = {1'b0, a_val ^ b_val};
			endcase
		end
		z_new   = keep_zs ? m_z : (res == 16'h0);
		s_new   = keep_zs ? m_s : res[15];
		does_wb = (cls == INS_ALU_SINGLE) || !(op == 4'd8 || op == 4'd9);
		is_alu  = cls inside {INS_ALU_SINGLE, INS_ALU_REG, INS_ALU_IMM};
		acc     = issue_valid && issue_ready;
	end

	// ============================================================
	// expected issue side outputs
	// ============================================================

	always_comb begin
		reads_a = cls inside {INS_ALU_SINGLE, INS_ALU_REG, INS_ALU_IMM, INS_BRANCH, INS_RET,
			INS_LOAD_STORE, INS_PEEK_POKE};
		reads_b = cls inside {INS_ALU_REG, INS_LOAD_STORE, INS_PEEK_POKE};
		hazard  = (cls == INS_BRANCH) && (|p_v); // flags still moving
		for (int i = 0; i < 2; i++) begin
			if (p_wb[i] && ((reads_a && p_dst[i] == instruction[7:4])
					|| (reads_b && p_dst[i] == instruction[3:0])))
				hazard = 1'b1;
		end
		exp_ready = !hazard;
		exp_pc_ld = 1'b0;
		exp_pc    = a_val;
		if (acc && cls == INS_BRANCH) begin
			exp_pc = a_val + imm;
			case (op)
				4'd0: exp_pc_ld = 1'b1;
				4'd1: exp_pc_ld = m_z;
				4'd2: exp_pc_ld = !m_z;
				4'd3: exp_pc_ld = m_c;
				4'd4: exp_pc_ld = !m_c;
				4'd5: exp_pc_ld = m_s;
				4'd6: exp_pc_ld = !m_s;
				default: exp_pc_ld = 1'b0;
			endcase
		end else if (acc && cls == INS_RET) begin
			exp_pc_ld = 1'b1;
		end else if (acc && cls == INS_INT) begin
			exp_pc_ld = 1'b1;
			exp_pc    = {11'h0, instruction[3:0], 1'b0};
		end
		exp_addr = b_reg + imm;
		exp_mem  = (acc && cls == INS_LOAD_STORE) ? {!instruction[8], instruction[8]} : 2'b00;
		exp_port = (acc && cls == INS_PEEK_POKE) ? {!instruction[8], instruction[8]} : 2'b00;
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 16; i++)
				shadow[i] <= '0;
			{m_z, m_c, m_s, m_i} <= '0;
			p_v    <= '0;
			p_wb   <= '0;
			stalls <= 0;
		end else begin
			p_v       <= {p_v[0], acc && is_alu};
			p_wb      <= {p_wb[0], acc && is_alu && does_wb};
			p_dst[0]  <= instruction[7:4];
			p_data[0] <= res;
			p_zcs[0]  <= {z_new, c_new, s_new};
			p_dst[1]  <= p_dst[0];
			p_data[1] <= p_data[0];
			p_zcs[1]  <= p_zcs[0];
			if (acc && is_alu) begin
				{m_z, m_c, m_s} <= {z_new, c_new, s_new};
				if (does_wb)
					shadow[instruction[7:4]] <= res;
			end
			if (acc && cls == INS_INT_EN)
				m_i <= instruction[0];
			if (issue_valid && !issue_ready)
				stalls <= stalls + 1;
		end
	end

	// ============================================================
	// assertions
	// ============================================================

	a_ready: assert property (@(posedge CLK) disable iff (!RSTb)
		issue_valid |-> issue_ready == exp_ready)
		else report_mismatch("issue_ready", 16'($sampled(exp_ready)), 16'($sampled(issue_ready)));
	a_wb_en: assert property (@(posedge CLK) disable iff (!RSTb) wb_en == p_wb[1])
		else report_mismatch("wb_en", 16'($sampled(p_wb[1])), 16'($sampled(wb_en)));
	a_wb_reg: assert property (@(posedge CLK) disable iff (!RSTb) p_wb[1] |-> wb_reg == p_dst[1])
		else report_mismatch("wb_reg", 16'($sampled(p_dst[1])), 16'($sampled(wb_reg)));
	a_wb_data: assert property (@(posedge CLK) disable iff (!RSTb)
		p_wb[1] |-> wb_data == p_data[1])
		else report_mismatch("wb_data", $sampled(p_data[1]), $sampled(wb_data));
	a_flags: assert property (@(posedge CLK) disable iff (!RSTb) p_v[1] |-> {Z, C, S} == p_zcs[1])
		else report_mismatch("ZCS", 16'($sampled(p_zcs[1])), 16'($sampled({Z, C, S})));
	a_load_pc: assert property (@(posedge CLK) disable iff (!RSTb) load_pc == exp_pc_ld)
		else report_mismatch("load_pc", 16'($sampled(exp_pc_ld)), 16'($sampled(load_pc)));
	a_new_pc: assert property (@(posedge CLK) disable iff (!RSTb) exp_pc_ld |-> new_pc == exp_pc)
		else report_mismatch("new_pc", $sampled(exp_pc), $sampled(new_pc));
	a_mem_strobe: assert property (@(posedge CLK) disable iff (!RSTb)
		{load_memory, store_memory} == exp_mem)
		else report_mismatch("load_memory/store_memory", 16'($sampled(exp_mem)),
			16'($sampled({load_memory, store_memory})));
	a_mem_addr: assert property (@(posedge CLK) disable iff (!RSTb)
		(|exp_mem) |-> load_store_address == exp_addr)
		else report_mismatch("load_store_address", $sampled(exp_addr),
			$sampled(load_store_address));
	a_mem_data: assert property (@(posedge CLK) disable iff (!RSTb)
		exp_mem[0] |-> memory_out == a_val)
		else report_mismatch("memory_out", $sampled(a_val), $sampled(memory_out));
	a_port_strobe: assert property (@(posedge CLK) disable iff (!RSTb)
		{port_rd, port_wr} == exp_port)
		else report_mismatch("port_rd/port_wr", 16'($sampled(exp_port)),
			16'($sampled({port_rd, port_wr})));
	a_port_addr: assert property (@(posedge CLK) disable iff (!RSTb)
		(|exp_port) |-> port_address == exp_addr)
		else report_mismatch("port_address", $sampled(exp_addr), $sampled(port_address));
	a_port_data: assert property (@(posedge CLK) disable iff (!RSTb)
		exp_port[0] |-> port_out == a_val)
		else report_mismatch("port_out", $sampled(a_val), $sampled(port_out));
	a_int_flag: assert property (@(posedge CLK) disable iff (!RSTb) I == m_i)
		else report_mismatch("I", 16'($sampled(m_i)), 16'($sampled(I)));

endmodule

// File: tb_slurm16_exec_unit.sv
module tb_slurm16_exec_unit;

	timeunit 1ns;
	timeprecision 100ps;

	import slurm16_pkg::*;

	localparam int WAIT_LIMIT = 32; // cycles per wait loop

	logic       CLK;
	logic       RSTb;
	logic       issue_valid;
	logic       issue_ready;
	word_t      instruction;
	word_t      imm;
	logic       load_memory;
	logic       store_memory;
	addr_t      load_store_address;
	word_t      memory_out;
	logic       port_rd;
	logic       port_wr;
	addr_t      port_address;
	word_t      port_out;
	logic       load_pc;
	addr_t      new_pc;
	logic       wb_en;
	reg_idx_t   wb_reg;
	word_t      wb_data;
	logic       Z;
	logic       C;
	logic       S;
	logic       I;
	integer     seed;
	int         issued;
	int         extra_errors;

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	slurm16_cpu_exec_unit #(.BITS(16), .ADDRESS_BITS(16)) u_slurm16_cpu_exec_unit (.*);

	tb_slurm16_checks u_checks (.*);

	function automatic word_t encode(input logic [3:0] cls, input logic [3:0] op,
			input logic [3:0] ra, input logic [3:0] rb);
		return {cls, op, ra, rb};
	endfunction

	function automatic word_t random_word();
		return word_t'($random(seed));
	endfunction

	function automatic logic [3:0] pick_below(input int n);
		return 4'($unsigned($random(seed)) % n);
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$finish;
	endtask

	// called on a rising edge, returns on the accepting edge
	task automatic issue_ins(input word_t ins, input word_t value);
		int waited;
		issue_valid <= 1'b1;
		instruction <= ins;
		imm         <= value;
		waited = 0;
		@(negedge CLK);
		while (!issue_ready && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge CLK);
		end
		if (!issue_ready) begin
			abort_run("issue_ready stayed low longer than the wait limit");
		end else begin
			@(posedge CLK);
			issued++;
		end
	endtask

	task automatic wait_writeback();
		int waited;
		issue_valid <= 1'b0;
		waited = 0;
		@(negedge CLK);
		while (!wb_en && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge CLK);
		end
		if (!wb_en)
			abort_run("wb_en never rose after an ALU issue");
		else
			@(posedge CLK);
	endtask

	task automatic idle(input int cycles);
		issue_valid <= 1'b0;
		repeat (cycles) @(posedge CLK);
	endtask

	initial begin
		int         k;
		logic [3:0] cls_pick;
		seed         = 32'h51aa_1eeb;
		issued       = 0;
		extra_errors = 0;
		RSTb        <= 1'b0;
		issue_valid <= 1'b0;
		instruction <= '0;
		imm         <= '0;
		repeat (5) @(posedge CLK);
		RSTb <= 1'b1;
		@(posedge CLK);

		// ============================================================
		// register seeding and directed carry chain
		// ============================================================
		for (k = 1; k < 16; k++)
			issue_ins(encode(INS_ALU_IMM, 4'd0, 4'(k), 4'd0), random_word()); // mov imm
		issue_ins(encode(INS_ALU_IMM, 4'd0, 4'd1, 4'd0), 16'hffff);
		issue_ins(encode(INS_ALU_IMM, 4'd0, 4'd2, 4'd0), 16'h0001);
		issue_ins(encode(INS_ALU_REG, 4'd1, 4'd1, 4'd2), '0); // add, waits on r2
		issue_ins(encode(INS_ALU_REG, 4'd2, 4'd3, 4'd4), '0); // adc after carry
		issue_ins(encode(INS_ALU_SINGLE, 4'd3, 4'd5, 4'd0), '0); // rolc
		issue_ins(encode(INS_BRANCH, 4'd0, 4'd6, 4'd0), random_word()); // held by alu ops
		issue_ins(encode(INS_ALU_SINGLE, 4'd4, 4'd7, 4'd0), '0); // rorc
		wait_writeback();

		// random alu traffic, back to back
		for (k = 0; k < 64; k++) begin
			cls_pick = pick_below(3) + 4'd1;
			issue_ins(encode(cls_pick, (cls_pick == 4'd1) ? pick_below(5) : pick_below(10),
				pick_below(16), pick_below(16)), random_word());
		end
		issue_ins(encode(INS_ALU_REG, 4'd1, 4'd8, 4'd9), '0);
		wait_writeback();

		// ============================================================
		// branches, ret, int
		// ============================================================
		for (k = 0; k < 20; k++) begin
			issue_ins(encode(INS_ALU_REG, 4'd8, pick_below(16), pick_below(16)), '0); // cmp
			issue_ins(encode(INS_BRANCH, pick_below(8), pick_below(16), 4'd0), random_word());
		end
		for (k = 0; k < 4; k++) begin
			issue_ins(encode(INS_RET, 4'd0, pick_below(16), 4'd0), '0);
			issue_ins(encode(INS_INT, 4'd0, 4'd0, pick_below(16)), '0);
		end

		// memory and port requests, bit 8 picks store or poke
		for (k = 0; k < 24; k++)
			issue_ins(encode(k[0] ? INS_PEEK_POKE : INS_LOAD_STORE, pick_below(2),
				pick_below(16), pick_below(16)), random_word());

		issue_ins(encode(INS_INT_EN, 4'd0, 4'd0, 4'd1), '0);
		issue_ins(encode(INS_INT_EN, 4'd0, 4'd0, 4'd0), '0);
		issue_ins(encode(INS_INT_EN, 4'd0, 4'd0, 4'd1), '0);
		idle(4); // pipeline is two stages deep

		if (u_checks.stalls == 0) begin
			$display("the interlock never held back an offered instruction");
			extra_errors++;
		end
		$display("issued %0d, stall cycles %0d, assertion errors %0d, other errors %0d",
			issued, u_checks.stalls, u_checks.errors, extra_errors);
		if (u_checks.errors + extra_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
